/* alu_pkg.sv */
/* Operation word of the ALU bus, function codes and the series
   coefficients used by the sin, cos and 1/(1+x) engines. */
`default_nettype none

package alu_pkg;

    // Bit 8 of the operation word
    localparam logic alu_mode_dsp  = 1'b0;
    localparam logic alu_mode_func = 1'b1;

    typedef enum logic [7:0] {
        func_sin          = 8'h00,
        func_cos          = 8'h01,
        func_inv_1_plus_x = 8'h02
    } func_t;

    typedef struct packed {
        logic             mode;
        dsp_pkg::dsp_op_t op;
    } alu_dsp_view_t;

    typedef struct packed {
        logic  mode;
        func_t code;
    } alu_func_view_t;

    // Same 9-bit word, read by mode
    typedef union packed {
        alu_dsp_view_t  dsp;
        alu_func_view_t func;
    } alu_op_u;

    // --------------------
    // Taylor terms, constant term first, 16 fraction bits
    localparam logic signed [dsp_pkg::dsp_ab_w-1:0] cos_coef [4] = '{
        18'sd65536, -18'sd32768, 18'sd2731, -18'sd91
    };
    localparam logic signed [dsp_pkg::dsp_ab_w-1:0] sin_coef [4] = '{
        18'sd65536, -18'sd10923, 18'sd546, -18'sd13
    };

    localparam int recip_terms = 8;
    localparam logic signed [dsp_pkg::dsp_ab_w-1:0] one_fx = 18'sd65536;

endpackage

`default_nettype wire

/* alu_recip_calc.sv */
/* Series engine for 1/(1+x) on both lanes. Repeats h = 1 - x*h on the
   shared slices, starting from h = 1, and pulses done at the end. */
`default_nettype none

module alu_recip_calc (
    input  logic                                reset,
    input  logic                                clk,
    input  logic                                start,
    input  logic signed [dsp_pkg::dsp_ab_w-1:0] xl,
    input  logic signed [dsp_pkg::dsp_ab_w-1:0] xr,
    output logic                                done,
    output logic signed [dsp_pkg::dsp_ab_w-1:0] resl,
    output logic signed [dsp_pkg::dsp_ab_w-1:0] resr,
    dsp_if.requester                            dsp
);
    import dsp_pkg::*;
    import alu_pkg::*;

    logic                       busy;
    logic [1:0]                 phase;
    logic [2:0]                 step;
    logic                       issue;
    logic                       finish;
    logic signed [dsp_ab_w-1:0] xl_q;
    logic signed [dsp_ab_w-1:0] xr_q;

    assign issue  = busy && (phase == 2'd0) && (step < 3'(recip_terms - 1));
    assign finish = busy && (phase == 2'd0) && (step == 3'(recip_terms - 1));

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            busy  <= 1'b0;
            phase <= 2'd0;
            step  <= 3'd0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                phase <= 2'd0;
                step  <= 3'd0;
            end else if (finish) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else if (busy) begin
                phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
                if (phase == 2'd2) begin
                    step <= step + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge reset) begin
        if (start) begin
            xl_q <= xl;
            xr_q <= xr;
        end
        if (finish) begin
            resl <= p_to_fx(dsp.p_l);
            resr <= p_to_fx(dsp.p_r);
        end
    end

    // First step starts from one, later ones from the last P
    always_comb begin
        dsp.op  = op_hold;
        dsp.a_l = '0;
        dsp.b_l = '0;
        dsp.c_l = '0;
        dsp.a_r = '0;
        dsp.b_r = '0;
        dsp.c_r = '0;
        if (issue) begin
            dsp.op          = '0;
            dsp.op.op_sub   = 1'b1;
            dsp.op.op_use_c = 1'b1;
            dsp.a_l = xl_q;
            dsp.a_r = xr_q;
            dsp.b_l = (step == 3'd0) ? one_fx : p_to_fx(dsp.p_l);
            dsp.b_r = (step == 3'd0) ? one_fx : p_to_fx(dsp.p_r);
            dsp.c_l = fx_to_c(one_fx);
            dsp.c_r = fx_to_c(one_fx);
        end
    end

endmodule

`default_nettype wire

/* alu_top.sv */
/* ALU bus slave. Decodes the operation word, passes DSP-mode requests
   straight to the two slices with a three-stage ack, and lends the
   slices to the sin/cos or 1/(1+x) engine during a function cycle. */
`default_nettype none

module alu_top (
    input  logic        reset,
    input  logic        clk,
    input  logic        alu_strobe,
    input  logic        alu_cycle,
    input  logic [8:0]  alu_op,
    input  logic [17:0] alu_al,
    input  logic [17:0] alu_bl,
    input  logic [17:0] alu_ar,
    input  logic [17:0] alu_br,
    input  logic [47:0] alu_cl,
    input  logic [47:0] alu_cr,
    output logic [47:0] alu_pl,
    output logic [47:0] alu_pr,
    output logic        alu_ack,
    output logic        alu_stall
);
    import dsp_pkg::*;
    import alu_pkg::*;

    alu_op_u                    op_w;
    logic                       dsp_mode;
    logic                       func_mode;
    logic                       trig_sel;
    logic                       recip_sel;
    logic [2:0]                 ack_q;
    logic                       trig_done;
    logic                       recip_done;
    logic signed [dsp_ab_w-1:0] trig_resl;
    logic signed [dsp_ab_w-1:0] trig_resr;
    logic signed [dsp_ab_w-1:0] recip_resl;
    logic signed [dsp_ab_w-1:0] recip_resr;

    dsp_if trig_dsp ();
    dsp_if recip_dsp ();
    dsp_if slice_dsp ();

    assign op_w      = alu_op;
    assign dsp_mode  = alu_cycle && (op_w.dsp.mode == alu_mode_dsp);
    assign func_mode = alu_cycle && (op_w.func.mode == alu_mode_func);
    assign trig_sel  = func_mode && (op_w.func.code == func_sin || op_w.func.code == func_cos);
    assign recip_sel = func_mode && (op_w.func.code == func_inv_1_plus_x);

    // Ack lines up with P of the slices
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            ack_q <= 3'b000;
        end else begin
            ack_q <= {ack_q[1:0], dsp_mode && alu_strobe};
        end
    end

    // --------------------
    // Slice sharing, idle cycles hold P
    always_comb begin
        slice_dsp.op  = op_hold;
        slice_dsp.a_l = '0;
        slice_dsp.b_l = '0;
        slice_dsp.c_l = '0;
        slice_dsp.a_r = '0;
        slice_dsp.b_r = '0;
        slice_dsp.c_r = '0;
        if (dsp_mode && alu_strobe) begin
            slice_dsp.op  = op_w.dsp.op;
            slice_dsp.a_l = alu_al;
            slice_dsp.b_l = alu_bl;
            slice_dsp.c_l = alu_cl;
            slice_dsp.a_r = alu_ar;
            slice_dsp.b_r = alu_br;
            slice_dsp.c_r = alu_cr;
        end else if (trig_sel) begin
            slice_dsp.op  = trig_dsp.op;
            slice_dsp.a_l = trig_dsp.a_l;
            slice_dsp.b_l = trig_dsp.b_l;
            slice_dsp.c_l = trig_dsp.c_l;
            slice_dsp.a_r = trig_dsp.a_r;
            slice_dsp.b_r = trig_dsp.b_r;
            slice_dsp.c_r = trig_dsp.c_r;
        end else if (recip_sel) begin
            slice_dsp.op  = recip_dsp.op;
            slice_dsp.a_l = recip_dsp.a_l;
            slice_dsp.b_l = recip_dsp.b_l;
            slice_dsp.c_l = recip_dsp.c_l;
            slice_dsp.a_r = recip_dsp.a_r;
            slice_dsp.b_r = recip_dsp.b_r;
            slice_dsp.c_r = recip_dsp.c_r;
        end
    end

    assign trig_dsp.p_l  = slice_dsp.p_l;
    assign trig_dsp.p_r  = slice_dsp.p_r;
    assign recip_dsp.p_l = slice_dsp.p_l;
    assign recip_dsp.p_r = slice_dsp.p_r;

    // Bus responses
    always_comb begin
        alu_ack   = 1'b0;
        alu_stall = 1'b0;
        alu_pl    = '0;
        alu_pr    = '0;
        if (dsp_mode) begin
            alu_ack = ack_q[2];
            alu_pl  = slice_dsp.p_l;
            alu_pr  = slice_dsp.p_r;
        end else if (trig_sel) begin
            alu_ack   = trig_done;
            alu_stall = !trig_done;
            alu_pl    = 48'(trig_resl);
            alu_pr    = 48'(trig_resr);
        end else if (recip_sel) begin
            alu_ack   = recip_done;
            alu_stall = !recip_done;
            alu_pl    = 48'(recip_resl);
            alu_pr    = 48'(recip_resr);
        end
    end

    // --------------------
    alu_trig_calc trig_calc (
        .reset    (reset),
        .clk      (clk),
        .start    (trig_sel && alu_strobe),
        .func_sel (op_w.func.code),
        .xl       (alu_al),
        .xr       (alu_ar),
        .done     (trig_done),
        .resl     (trig_resl),
        .resr     (trig_resr),
        .dsp      (trig_dsp)
    );

    alu_recip_calc recip_calc (
        .reset (reset),
        .clk   (clk),
        .start (recip_sel && alu_strobe),
        .xl    (alu_al),
        .xr    (alu_ar),
        .done  (recip_done),
        .resl  (recip_resl),
        .resr  (recip_resr),
        .dsp   (recip_dsp)
    );

    dsp_slice slice_l (
        .reset (reset),
        .clk   (clk),
        .op    (slice_dsp.op),
        .a     (slice_dsp.a_l),
        .b     (slice_dsp.b_l),
        .c     (slice_dsp.c_l),
        .p     (slice_dsp.p_l)
    );

    dsp_slice slice_r (
        .reset (reset),
        .clk   (clk),
        .op    (slice_dsp.op),
        .a     (slice_dsp.a_r),
        .b     (slice_dsp.b_r),
        .c     (slice_dsp.c_r),
        .p     (slice_dsp.p_r)
    );

endmodule

`default_nettype wire

/* alu_top_sva.sv */
/* Bus protocol checks for alu_top, attached to every instance by bind.
   Failures show up as assertion errors in the simulation log. */
`default_nettype none

module alu_top_sva (
    input logic       reset,
    input logic       clk,
    input logic       alu_strobe,
    input logic       alu_cycle,
    input logic [8:0] alu_op,
    input logic       alu_ack,
    input logic       alu_stall
);
    import alu_pkg::*;

    logic dsp_req;
    logic func_cycle;

    assign dsp_req    = alu_cycle && alu_strobe && (alu_op[8] == alu_mode_dsp);
    assign func_cycle = alu_cycle && (alu_op[8] == alu_mode_func);

    ack_stall_excl: assert property (
        @(posedge reset) disable iff (clk) !(alu_ack && alu_stall)
    ) else $error("ack and stall are high in the same cycle");

    // P and ack arrive together three cycles on
    dsp_ack_latency: assert property (
        @(posedge reset) disable iff (clk) dsp_req |-> ##3 alu_ack
    ) else $error("DSP request was not acked three cycles later");

    func_stall_hold: assert property (
        @(posedge reset) disable iff (clk) (func_cycle && !alu_ack) |-> alu_stall
    ) else $error("stall dropped before ack in a function cycle");

endmodule

bind alu_top alu_top_sva sva (
    .reset      (reset),
    .clk        (clk),
    .alu_strobe (alu_strobe),
    .alu_cycle  (alu_cycle),
    .alu_op     (alu_op),
    .alu_ack    (alu_ack),
    .alu_stall  (alu_stall)
);

`default_nettype wire

/* alu_trig_calc.sv */
/* Series engine for sin and cos on both lanes. Squares x, runs the
   Horner steps on the shared slices and, for sin, multiplies by x. */
`default_nettype none

module alu_trig_calc (
    input  logic                                reset,
    input  logic                                clk,
    input  logic                                start,
    input  alu_pkg::func_t                      func_sel,
    input  logic signed [dsp_pkg::dsp_ab_w-1:0] xl,
    input  logic signed [dsp_pkg::dsp_ab_w-1:0] xr,
    output logic                                done,
    output logic signed [dsp_pkg::dsp_ab_w-1:0] resl,
    output logic signed [dsp_pkg::dsp_ab_w-1:0] resr,
    dsp_if.requester                            dsp
);
    import dsp_pkg::*;
    import alu_pkg::*;

    logic                       busy;
    logic [1:0]                 phase;
    logic [2:0]                 step;
    logic [2:0]                 last_step;
    logic                       issue;
    logic                       finish;
    func_t                      func_q;
    logic signed [dsp_ab_w-1:0] xl_q;
    logic signed [dsp_ab_w-1:0] xr_q;
    logic signed [dsp_ab_w-1:0] sl_q;
    logic signed [dsp_ab_w-1:0] sr_q;
    logic signed [dsp_ab_w-1:0] hl;
    logic signed [dsp_ab_w-1:0] hr;
    logic signed [dsp_ab_w-1:0] coef_top;
    logic signed [dsp_ab_w-1:0] coef_k;
    logic [1:0]                 cidx;

    // Result of the step that just left the slices
    assign hl = p_to_fx(dsp.p_l);
    assign hr = p_to_fx(dsp.p_r);

    // Step 0 squares, 1..3 Horner, 4 is the sin multiply
    assign last_step = (func_q == func_sin) ? 3'd4 : 3'd3;
    assign issue     = busy && (phase == 2'd0) && (step <= last_step);
    assign finish    = busy && (phase == 2'd0) && (step > last_step);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            busy  <= 1'b0;
            phase <= 2'd0;
            step  <= 3'd0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                phase <= 2'd0;
                step  <= 3'd0;
            end else if (finish) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else if (busy) begin
                if (phase == 2'd2) begin
                    phase <= 2'd0;
                    step  <= step + 3'd1;
                end else begin
                    phase <= phase + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge reset) begin
        if (start) begin
            func_q <= func_sel;
            xl_q   <= xl;
            xr_q   <= xr;
        end
        if (issue && step == 3'd1) begin
            sl_q <= hl;
            sr_q <= hr;
        end
        if (finish) begin
            resl <= hl;
            resr <= hr;
        end
    end

    // --------------------
    // Slice request
    always_comb begin
        cidx     = 2'(3'd3 - step);
        coef_top = (func_q == func_sin) ? sin_coef[3] : cos_coef[3];
        coef_k   = (func_q == func_sin) ? sin_coef[cidx] : cos_coef[cidx];

        dsp.op  = op_hold;
        dsp.a_l = '0;
        dsp.b_l = '0;
        dsp.c_l = '0;
        dsp.a_r = '0;
        dsp.b_r = '0;
        dsp.c_r = '0;
        if (issue) begin
            dsp.op = '0;
            case (step)
                3'd0: begin
                    dsp.a_l = xl_q;
                    dsp.b_l = xl_q;
                    dsp.a_r = xr_q;
                    dsp.b_r = xr_q;
                end
                3'd1, 3'd2, 3'd3: begin
                    dsp.op.op_use_c = 1'b1;
                    dsp.a_l = (step == 3'd1) ? hl : sl_q;
                    dsp.a_r = (step == 3'd1) ? hr : sr_q;
                    dsp.b_l = (step == 3'd1) ? coef_top : hl;
                    dsp.b_r = (step == 3'd1) ? coef_top : hr;
                    dsp.c_l = fx_to_c(coef_k);
                    dsp.c_r = fx_to_c(coef_k);
                end
                default: begin
                    dsp.a_l = xl_q;
                    dsp.b_l = hl;
                    dsp.a_r = xr_q;
                    dsp.b_r = hr;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* dsp_if.sv */
/* One request to the left and right DSP slices and their results.
   Engines and the top drive the requester side, slices the other. */
`default_nettype none

interface dsp_if;
    import dsp_pkg::*;

    dsp_op_t                     op;
    logic signed [dsp_ab_w-1:0]  a_l;
    logic signed [dsp_ab_w-1:0]  b_l;
    logic signed [dsp_c_w-1:0]   c_l;
    logic signed [dsp_ab_w-1:0]  a_r;
    logic signed [dsp_ab_w-1:0]  b_r;
    logic signed [dsp_c_w-1:0]   c_r;
    logic signed [dsp_p_w-1:0]   p_l;
    logic signed [dsp_p_w-1:0]   p_r;

    modport requester (
        output op, a_l, b_l, c_l, a_r, b_r, c_r,
        input  p_l, p_r
    );

    modport slices (
        input  op, a_l, b_l, c_l, a_r, b_r, c_r,
        output p_l, p_r
    );

endinterface

`default_nettype wire

/* dsp_pkg.sv */
/* Widths and opcode layout of the DSP multiply-add slices, with the
   fixed-point helpers that move values into and out of a slice.
   Imported by the slices, the series engines and the ALU top. */
`default_nettype none

package dsp_pkg;

    localparam int dsp_ab_w  = 18;
    localparam int dsp_c_w   = 48;
    localparam int dsp_p_w   = 48;
    localparam int frac_bits = 16;

    // Slice opcode, only the low three bits are decoded
    typedef struct packed {
        logic [4:0] rsvd;
        logic       op_acc;
        logic       op_use_c;
        logic       op_sub;
    } dsp_op_t;

    // Zero product plus previous P, so P keeps its value
    localparam dsp_op_t op_hold = '{rsvd: 5'd0, op_acc: 1'b1, op_use_c: 1'b0, op_sub: 1'b0};

    // Fixed-point value lined up as an addend
    function automatic logic signed [dsp_c_w-1:0] fx_to_c(
        input logic signed [dsp_ab_w-1:0] v
    );
        return dsp_c_w'(v) <<< frac_bits;
    endfunction

    // Truncate a product back to operand format
    function automatic logic signed [dsp_ab_w-1:0] p_to_fx(
        input logic signed [dsp_p_w-1:0] p
    );
        return p[frac_bits +: dsp_ab_w];
    endfunction

endpackage

`default_nettype wire

/* dsp_slice.sv */
/* Pipelined signed multiply-add for one lane. Takes a request every
   cycle and presents P three cycles later, op bits travel with the data. */
`default_nettype none

module dsp_slice (
    input  logic                                reset,
    input  logic                                clk,
    input  dsp_pkg::dsp_op_t                    op,
    input  logic signed [dsp_pkg::dsp_ab_w-1:0] a,
    input  logic signed [dsp_pkg::dsp_ab_w-1:0] b,
    input  logic signed [dsp_pkg::dsp_c_w-1:0]  c,
    output logic signed [dsp_pkg::dsp_p_w-1:0]  p
);
    import dsp_pkg::*;

    dsp_op_t                       op_s1;
    dsp_op_t                       op_s2;
    logic signed [dsp_ab_w-1:0]    a_s1;
    logic signed [dsp_ab_w-1:0]    b_s1;
    logic signed [dsp_c_w-1:0]     c_s1;
    logic signed [2*dsp_ab_w-1:0]  m_s2;
    logic signed [dsp_c_w-1:0]     c_s2;
    logic signed [dsp_p_w-1:0]     prod;
    logic signed [dsp_p_w-1:0]     addend;

    // Opcode pipeline and P register
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_s1 <= '0;
            op_s2 <= '0;
            p     <= '0;
        end else begin
            op_s1 <= op;
            op_s2 <= op_s1;
            p     <= op_s2.op_sub ? addend - prod : addend + prod;
        end
    end

    // Operand and product registers
    always_ff @(posedge reset) begin
        a_s1 <= a;
        b_s1 <= b;
        c_s1 <= c;
        m_s2 <= a_s1 * b_s1;
        c_s2 <= c_s1;
    end

    always_comb begin
        prod   = dsp_p_w'(m_s2);
        addend = op_s2.op_use_c ? c_s2 : '0;
        // accumulate onto the value P holds now
        if (op_s2.op_acc) begin
            addend = addend + p;
        end
    end

endmodule

`default_nettype wire

/* files.f */
dsp_pkg.sv
alu_pkg.sv
dsp_if.sv
dsp_slice.sv
alu_trig_calc.sv
alu_recip_calc.sv
alu_top.sv
alu_top_sva.sv
tb_alu_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench printed its pass line
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_alu_top \
    && ./obj_dir/Vtb_alu_top | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    || exit 1

/* tb_alu_top.sv */
/* Table-driven testbench for alu_top. Fills a table of DSP and function
   requests, works out the expected P from a reference model and replays
   the table on the bus, checking ack, stall and both result lanes. */
`default_nettype none

module tb_alu_top;
    import dsp_pkg::*;
    import alu_pkg::*;

    localparam int n_ent      = 32;
    localparam int max_cycles = n_ent * 30 + 50;

    // Clock is reset, reset is clk, as on the DUT
    logic        reset;
    logic        clk;
    logic        alu_strobe;
    logic        alu_cycle;
    logic [8:0]  alu_op;
    logic [17:0] alu_al;
    logic [17:0] alu_bl;
    logic [17:0] alu_ar;
    logic [17:0] alu_br;
    logic [47:0] alu_cl;
    logic [47:0] alu_cr;
    logic [47:0] alu_pl;
    logic [47:0] alu_pr;
    logic        alu_ack;
    logic        alu_stall;

    logic [8:0]                 e_op   [n_ent];
    logic signed [dsp_ab_w-1:0] e_al   [n_ent];
    logic signed [dsp_ab_w-1:0] e_bl   [n_ent];
    logic signed [dsp_ab_w-1:0] e_ar   [n_ent];
    logic signed [dsp_ab_w-1:0] e_br   [n_ent];
    logic signed [dsp_c_w-1:0]  e_cl   [n_ent];
    logic signed [dsp_c_w-1:0]  e_cr   [n_ent];
    logic                       e_next [n_ent];
    logic [47:0]                exp_pl [n_ent];
    logic [47:0]                exp_pr [n_ent];

    int seed;
    int idx;
    int cnt;
    int cycles;

    alu_top dut (
        .reset     (reset),
        .clk       (clk),
        .alu_strobe(alu_strobe),
        .alu_cycle (alu_cycle),
        .alu_op    (alu_op),
        .alu_al    (alu_al),
        .alu_bl    (alu_bl),
        .alu_ar    (alu_ar),
        .alu_br    (alu_br),
        .alu_cl    (alu_cl),
        .alu_cr    (alu_cr),
        .alu_pl    (alu_pl),
        .alu_pr    (alu_pr),
        .alu_ack   (alu_ack),
        .alu_stall (alu_stall)
    );

    always #20 reset = ~reset;

    // --------------------
    // Reference model
    function automatic logic signed [dsp_p_w-1:0] slice_model(
        input logic [7:0]                 op_bits,
        input logic signed [dsp_ab_w-1:0] a,
        input logic signed [dsp_ab_w-1:0] b,
        input logic signed [dsp_c_w-1:0]  c,
        input logic signed [dsp_p_w-1:0]  prev
    );
        dsp_op_t                    o;
        logic signed [dsp_p_w-1:0]  prod;
        logic signed [dsp_p_w-1:0]  addend;
        o      = op_bits;
        prod   = dsp_p_w'(a) * dsp_p_w'(b);
        addend = o.op_use_c ? c : '0;
        if (o.op_acc) begin
            addend = addend + prev;
        end
        return o.op_sub ? addend - prod : addend + prod;
    endfunction

    function automatic logic signed [dsp_ab_w-1:0] fx_trunc(
        input logic signed [dsp_p_w-1:0] p
    );
        logic signed [dsp_p_w-1:0] sh;
        sh = p >>> frac_bits;
        return sh[dsp_ab_w-1:0];
    endfunction

    function automatic logic signed [dsp_ab_w-1:0] trig_model(
        input  logic                       is_sin,
        input  logic signed [dsp_ab_w-1:0] x,
        output logic signed [dsp_p_w-1:0]  p_last
    );
        logic signed [dsp_ab_w-1:0] s;
        logic signed [dsp_ab_w-1:0] h;
        logic signed [dsp_ab_w-1:0] cf;
        int                         k;
        p_last = dsp_p_w'(x) * dsp_p_w'(x);
        s      = fx_trunc(p_last);
        h      = is_sin ? sin_coef[3] : cos_coef[3];
        for (k = 2; k >= 0; k--) begin
            cf     = is_sin ? sin_coef[k] : cos_coef[k];
            p_last = (dsp_p_w'(cf) <<< frac_bits) + dsp_p_w'(s) * dsp_p_w'(h);
            h      = fx_trunc(p_last);
        end
        if (is_sin) begin
            p_last = dsp_p_w'(x) * dsp_p_w'(h);
            h      = fx_trunc(p_last);
        end
        return h;
    endfunction

    function automatic logic signed [dsp_ab_w-1:0] recip_model(
        input  logic signed [dsp_ab_w-1:0] x,
        output logic signed [dsp_p_w-1:0]  p_last
    );
        logic signed [dsp_ab_w-1:0] h;
        int                         k;
        h      = one_fx;
        p_last = '0;
        for (k = 0; k < recip_terms - 1; k++) begin
            p_last = (dsp_p_w'(one_fx) <<< frac_bits) - dsp_p_w'(x) * dsp_p_w'(h);
            h      = fx_trunc(p_last);
        end
        return h;
    endfunction

    // --------------------
    // Table setup
    task automatic fill_table();
        int    i;
        int    sel;
        func_t f;
        for (i = 0; i < n_ent; i++) begin
            e_al[i]   = dsp_ab_w'($random(seed));
            e_bl[i]   = dsp_ab_w'($random(seed));
            e_ar[i]   = dsp_ab_w'($random(seed));
            e_br[i]   = dsp_ab_w'($random(seed));
            e_cl[i]   = dsp_c_w'({$random(seed), $random(seed)});
            e_cr[i]   = dsp_c_w'({$random(seed), $random(seed)});
            e_next[i] = 1'b0;
            if (i < 8) begin
                e_op[i] = {alu_mode_dsp, 8'(i)};
            end else if (i < 14 || i >= 30 || i % 2 == 0) begin
                e_op[i] = {alu_mode_dsp, 5'd0, (i >= 14), 2'($random(seed))};
            end else begin
                sel = $unsigned($random(seed)) % 3;
                case (sel)
                    0:       f = func_sin;
                    1:       f = func_cos;
                    default: f = func_inv_1_plus_x;
                endcase
                e_op[i] = {alu_mode_func, f};
                // keep |x| below one half
                e_al[i] = dsp_ab_w'($random(seed) % 32768);
                e_ar[i] = dsp_ab_w'($random(seed) % 32768);
            end
        end
        // Reserved opcode bits must be ignored
        e_op[7] = {alu_mode_dsp, 8'hff};
        e_op[8] = {alu_mode_func, func_cos};
        e_al[8] = 18'sd16384;
        e_ar[8] = -18'sd24576;
        e_op[9] = {alu_mode_func, func_sin};
        e_al[9] = 18'sd19661;
        e_ar[9] = -18'sd29491;
        e_op[10] = {alu_mode_func, func_inv_1_plus_x};
        e_al[10] = 18'sd13107;
        e_ar[10] = -18'sd16384;
        e_next[11] = 1'b1;
        e_next[12] = 1'b1;
        e_next[30] = 1'b1;
    endtask

    // P carries over between entries, function steps included
    task automatic compute_expected();
        logic signed [dsp_p_w-1:0] p_l;
        logic signed [dsp_p_w-1:0] p_r;
        logic [7:0]                code;
        int                        i;
        p_l = '0;
        p_r = '0;
        for (i = 0; i < n_ent; i++) begin
            code = e_op[i][7:0];
            if (e_op[i][8] == alu_mode_dsp) begin
                p_l = slice_model(code, e_al[i], e_bl[i], e_cl[i], p_l);
                p_r = slice_model(code, e_ar[i], e_br[i], e_cr[i], p_r);
                exp_pl[i] = p_l;
                exp_pr[i] = p_r;
            end else if (code == func_inv_1_plus_x) begin
                exp_pl[i] = dsp_p_w'(recip_model(e_al[i], p_l));
                exp_pr[i] = dsp_p_w'(recip_model(e_ar[i], p_r));
            end else begin
                exp_pl[i] = dsp_p_w'(trig_model(code == func_sin, e_al[i], p_l));
                exp_pr[i] = dsp_p_w'(trig_model(code == func_sin, e_ar[i], p_r));
            end
        end
    endtask

    // --------------------
    // Bus driving and checks
    task automatic check_value(input string what, input logic [47:0] got,
                               input logic [47:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_idle();
        check_value("idle ack", 48'(alu_ack), 48'd0);
        check_value("idle stall", 48'(alu_stall), 48'd0);
        check_value("idle pl", alu_pl, 48'd0);
        check_value("idle pr", alu_pr, 48'd0);
    endtask

    task automatic drive_idle();
        alu_cycle  = 1'b0;
        alu_strobe = 1'b0;
        alu_op     = '0;
        alu_al     = '0;
        alu_bl     = '0;
        alu_ar     = '0;
        alu_br     = '0;
        alu_cl     = '0;
        alu_cr     = '0;
    endtask

    task automatic drive_entry(input int i, input logic strobe);
        alu_cycle  = 1'b1;
        alu_strobe = strobe;
        alu_op     = e_op[i];
        alu_al     = e_al[i];
        alu_bl     = e_bl[i];
        alu_ar     = e_ar[i];
        alu_br     = e_br[i];
        alu_cl     = e_cl[i];
        alu_cr     = e_cr[i];
    endtask

    // Strobes on consecutive cycles, acks follow three cycles behind
    task automatic issue_dsp_group(input int first, input int n);
        int t;
        int k;
        for (t = 0; t < n + 4; t++) begin
            @(negedge reset);
            k = t - 3;
            if (t == 0) begin
                check_idle();
            end
            check_value("ack", 48'(alu_ack), (k >= 0 && k < n) ? 48'd1 : 48'd0);
            check_value("stall", 48'(alu_stall), 48'd0);
            if (k >= 0 && k < n) begin
                check_value("dsp pl", alu_pl, exp_pl[first + k]);
                check_value("dsp pr", alu_pr, exp_pr[first + k]);
            end
            if (t < n) begin
                drive_entry(first + t, 1'b1);
            end else if (t == n + 3) begin
                drive_idle();
            end else begin
                alu_strobe = 1'b0;
            end
        end
    endtask

    task automatic issue_func(input int i);
        @(negedge reset);
        check_idle();
        drive_entry(i, 1'b1);
        @(negedge reset);
        alu_strobe = 1'b0;
        while (alu_ack !== 1'b1) begin
            check_value("stall", 48'(alu_stall), 48'd1);
            @(negedge reset);
        end
        check_value("stall at ack", 48'(alu_stall), 48'd0);
        check_value("func pl", alu_pl, exp_pl[i]);
        check_value("func pr", alu_pr, exp_pr[i]);
        drive_idle();
    endtask

    // --------------------
    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge reset);
            cycles = cycles + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        seed  = 54;
        reset = 1'b0;
        clk   = 1'b1;
        drive_idle();
        fill_table();
        compute_expected();
        repeat (10) @(negedge reset);
        clk = 1'b0;
        idx = 0;
        while (idx < n_ent) begin
            if (e_op[idx][8] == alu_mode_dsp) begin
                cnt = 1;
                while (cnt < 3 && e_next[idx + cnt - 1]) begin
                    cnt = cnt + 1;
                end
                issue_dsp_group(idx, cnt);
                idx = idx + cnt;
            end else begin
                issue_func(idx);
                idx = idx + 1;
            end
        end
        @(negedge reset);
        check_idle();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
